// File: sim.f
+incdir+sim
logic/button_pkg.sv
logic/seg_game_pkg.sv
logic/button_conditioner.sv
logic/game_timer.sv
logic/game_fsm.sv
logic/segment_walker.sv
logic/segment_display.sv
logic/seg_game_top.sv
sim/seg_game_tb.sv

// File: sim/walk_model.svh
`ifndef WALK_MODEL_SVH
`define WALK_MODEL_SVH

// Walk table keyed by position, heading and the right, left, up pulse bits
function automatic cursor_t walk_next(cursor_t cur, btn_vec_t b);
    cursor_t nxt;
    nxt = cur;
    case ({cur.pos, cur.head, b.right, b.left, b.up})
        {POS_A, HEAD_RIGHT, 3'b100}: nxt = '{POS_B, HEAD_DOWN};
        {POS_A, HEAD_LEFT,  3'b010}: nxt = '{POS_F, HEAD_DOWN};
        {POS_B, HEAD_UP,    3'b010}: nxt = '{POS_A, HEAD_LEFT};
        {POS_B, HEAD_DOWN,  3'b100}: nxt = '{POS_G, HEAD_LEFT};
        {POS_B, HEAD_DOWN,  3'b001}: nxt = '{POS_C, HEAD_DOWN};
        {POS_C, HEAD_UP,    3'b010}: nxt = '{POS_G, HEAD_LEFT};
        {POS_C, HEAD_UP,    3'b001}: nxt = '{POS_B, HEAD_UP};
        {POS_C, HEAD_DOWN,  3'b100}: nxt = '{POS_D, HEAD_DOWN};
        {POS_D, HEAD_RIGHT, 3'b010}: nxt = '{POS_C, HEAD_UP};
        {POS_D, HEAD_LEFT,  3'b100}: nxt = '{POS_E, HEAD_UP};
        {POS_E, HEAD_UP,    3'b100}: nxt = '{POS_G, HEAD_RIGHT};
        {POS_E, HEAD_UP,    3'b001}: nxt = '{POS_F, HEAD_UP};
        {POS_E, HEAD_DOWN,  3'b010}: nxt = '{POS_D, HEAD_RIGHT};
        {POS_F, HEAD_UP,    3'b100}: nxt = '{POS_A, HEAD_RIGHT};
        {POS_F, HEAD_DOWN,  3'b010}: nxt = '{POS_G, HEAD_RIGHT};
        {POS_G, HEAD_RIGHT, 3'b010}: nxt = '{POS_B, HEAD_UP};
        {POS_G, HEAD_RIGHT, 3'b100}: nxt = '{POS_C, HEAD_DOWN};
        {POS_G, HEAD_LEFT,  3'b010}: nxt = '{POS_E, HEAD_DOWN};
        {POS_G, HEAD_LEFT,  3'b100}: nxt = '{POS_F, HEAD_UP};
        default: nxt = cur;
    endcase
    return nxt;
endfunction

// Expected active-low digit for a game state
function automatic seg_bits_t seg_pattern(game_phase_t ph, cursor_t cur, seg_bits_t rec,
                                          logic blink);
    seg_bits_t cur_bit;
    cur_bit = seg_bits_t'(1) << cur.pos;
    case (ph)
        PHASE_INITIAL: return ~(seg_bits_t'(1) << START_POS);
        PHASE_MOVING:  return ~cur_bit;
        // Cursor lit while blink is low
        PHASE_FALLING: return blink ? (rec | cur_bit) : (rec & ~cur_bit);
        default:       return SEG_ALL_DARK;
    endcase
endfunction

`endif

// File: sim/seg_game_tb.sv
`timescale 1ns/1ps

module seg_game_tb;
    import button_pkg::*;
    import seg_game_pkg::*;

    `include "walk_model.svh"

    localparam int HALF_CYCLES = 8;
    // About 60 presses of up to 17 cycles and two start waits, with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        rst;
    btn_vec_t    btn;
    btn_vec_t    btn_pulse;
    game_phase_t phase;
    seg_bits_t   seg;

    int          seed;
    int          cycles;
    int          value_errors;
    int          other_errors;
    string       test_name;

    // Expected game state, advanced on the falling edge
    game_phase_t exp_phase;
    cursor_t     exp_cur;
    seg_bits_t   exp_rec;
    int          exp_secs;

    seg_game_top #(
        .half_tick_cycles (HALF_CYCLES)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .btn_pulse (btn_pulse),
        .phase     (phase),
        .seg       (seg)
    );

    always #10 clk = ~clk;

    // Active edges since reset release
    always @(posedge clk) begin
        cycles <= rst ? 0 : cycles + 1;
    end

    task automatic check_seg(string name, seg_bits_t exp, seg_bits_t act);
        if (act !== exp) begin
            $display("Error %s: seg expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_phase(string name, game_phase_t exp, game_phase_t act);
        if (act !== exp) begin
            $display("Error %s: phase expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pulse(string name, btn_vec_t exp, btn_vec_t act);
        if (act !== exp) begin
            $display("Error %s: btn_pulse expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // Pulse is due 5 edges after the first high sample
    task automatic press(btn_vec_t b, int hold);
        btn_vec_t exp;
        btn = b;
        for (int i = 0; i < hold + 8; i++) begin
            @(posedge clk);
            #2;
            if (i == hold - 1) begin
                btn = '0;
            end
            @(negedge clk);
            exp = (i == 5 && hold >= DEBOUNCE_DEPTH) ? b : '0;
            check_pulse(test_name, exp, btn_pulse);
        end
        @(posedge clk);
        #2;
    endtask

    // Random right, left or up that stays out of the dead end at D
    function automatic btn_vec_t pick_button(cursor_t cur);
        btn_vec_t b;
        cursor_t  nxt;
        int       idx;
        idx = $unsigned($random(seed)) % 3;
        b = btn_vec_t'(4'b1000 >> idx);
        nxt = walk_next(cur, b);
        if (nxt.head == HEAD_DOWN && (nxt.pos == POS_C || nxt.pos == POS_D)) begin
            b = btn_vec_t'(4'b1000 >> ((idx + 1) % 3));
        end
        return b;
    endfunction

    task automatic wait_moving(output int n);
        n = 0;
        while (phase != PHASE_MOVING && n <= 8 * HALF_CYCLES) begin
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    always @(negedge clk) begin : compare
        cursor_t nxt;
        logic    half;
        logic    blink;
        if (rst) begin
            exp_phase = PHASE_INITIAL;
            exp_cur   = '{START_POS, START_HEAD};
            exp_rec   = SEG_ALL_DARK;
            exp_secs  = 0;
        end else begin
            // Half tick after every 8th edge, blink flips one edge later
            half  = cycles > 0 && cycles % HALF_CYCLES == 0;
            blink = cycles > 0 && ((cycles - 1) / HALF_CYCLES) % 2 == 1;
            check_phase(test_name, exp_phase, phase);
            check_seg(test_name, seg_pattern(exp_phase, exp_cur, exp_rec, blink), seg);
            nxt = walk_next(exp_cur, btn_pulse);
            case (exp_phase)
                PHASE_MOVING: begin
                    if (btn_pulse.down) begin
                        exp_rec = SEG_ALL_DARK;
                        exp_rec[nxt.pos] = 1'b0;
                        exp_phase = PHASE_FALLING;
                    end
                    exp_cur  = nxt;
                    exp_secs = 0;
                end
                PHASE_FALLING: begin
                    if (half && exp_rec == SEG_ALL_LIT) begin
                        exp_phase = PHASE_INITIAL;
                    end
                    exp_rec[nxt.pos] = 1'b0;
                    exp_cur  = nxt;
                    exp_secs = 0;
                end
                default: begin
                    exp_cur = '{START_POS, START_HEAD};
                    exp_rec = SEG_ALL_DARK;
                    if (half && cycles % (2 * HALF_CYCLES) == 0) begin
                        if (exp_secs == INITIAL_WAIT_SECONDS - 1) begin
                            exp_phase = PHASE_MOVING;
                        end
                        exp_secs++;
                    end
                end
            endcase
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Run timed out after %0d cycles before the tests finished", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        btn_vec_t b;
        int       n;
        rst = 1'b1;
        clk = 1'b0;
        btn = '0;
        seed = 46037;
        test_name = "reset";
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // Third second tick lands between 2 and 4 seconds in
        wait_moving(n);
        if (n < 4 * HALF_CYCLES || n > 8 * HALF_CYCLES) begin
            $display("Phase reached MOVING after %0d cycles, outside the expected window", n);
            other_errors++;
        end
        test_name = "debounce";
        press(btn_vec_t'(4'b1000), DEBOUNCE_DEPTH - 1);
        test_name = "falling";
        press(btn_vec_t'(4'b0001), 8);
        check_phase(test_name, PHASE_FALLING, phase);
        // From G heading left this lights every segment
        test_name = "fill";
        for (int i = 0; i < 6; i++) begin
            press(btn_vec_t'(i == 3 ? 4'b0010 : 4'b0100), 8);
        end
        check_phase(test_name, PHASE_INITIAL, phase);
        check_seg(test_name, 7'b011_1111, seg);
        test_name = "restart";
        wait_moving(n);
        if (n > 8 * HALF_CYCLES) begin
            $display("Phase did not reach MOVING again after the finished game");
            other_errors++;
        end
        test_name = "walk";
        for (int i = 0; i < 46; i++) begin
            if (i == 40) begin
                test_name = "visit";
                b = btn_vec_t'(4'b0001);
            end else begin
                b = pick_button(exp_cur);
            end
            // Every eighth press is held exactly the debounce depth
            press(b, i % 8 == 0 ? DEBOUNCE_DEPTH : 8);
        end
        $display("Summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: logic/seg_game_top.sv
`timescale 1ns/1ps

module seg_game_top #(
    parameter int half_tick_cycles = seg_game_pkg::HALF_TICK_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  button_pkg::btn_vec_t      btn,
    output button_pkg::btn_vec_t      btn_pulse,
    output seg_game_pkg::game_phase_t phase,
    output seg_game_pkg::seg_bits_t   seg
);
    import button_pkg::*;
    import seg_game_pkg::*;

    logic [BTN_COUNT-1:0] btn_level;
    logic [BTN_COUNT-1:0] btn_edge;
    logic                 half_tick;
    logic                 second_tick;
    cursor_t              cursor;
    seg_bits_t            record;
    logic                 all_lit;

    assign btn_level[BTN_RIGHT] = btn.right;
    assign btn_level[BTN_LEFT]  = btn.left;
    assign btn_level[BTN_UP]    = btn.up;
    assign btn_level[BTN_DOWN]  = btn.down;

    for (genvar i = 0; i < BTN_COUNT; i++) begin : g_btn
        button_conditioner u_cond (
            .clk   (clk),
            .rst   (rst),
            .level (btn_level[i]),
            .pulse (btn_edge[i])
        );
    end

    assign btn_pulse = '{
        right: btn_edge[BTN_RIGHT],
        left:  btn_edge[BTN_LEFT],
        up:    btn_edge[BTN_UP],
        down:  btn_edge[BTN_DOWN]
    };

    game_timer #(
        .half_tick_cycles (half_tick_cycles)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .half_tick   (half_tick),
        .second_tick (second_tick)
    );

    game_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .second_tick (second_tick),
        .half_tick   (half_tick),
        .down_pulse  (btn_pulse.down),
        .all_lit     (all_lit),
        .phase       (phase)
    );

    segment_walker u_walker (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .btn_pulse (btn_pulse),
        .cursor    (cursor),
        .record    (record),
        .all_lit   (all_lit)
    );

    segment_display u_display (
        .clk       (clk),
        .rst       (rst),
        .half_tick (half_tick),
        .phase     (phase),
        .cursor    (cursor),
        .record    (record),
        .seg       (seg)
    );

endmodule

// File: logic/segment_display.sv
`timescale 1ns/1ps

module segment_display (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      half_tick,
    input  seg_game_pkg::game_phase_t phase,
    input  seg_game_pkg::cursor_t     cursor,
    input  seg_game_pkg::seg_bits_t   record,
    output seg_game_pkg::seg_bits_t   seg
);
    import seg_game_pkg::*;

    logic blink;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink <= 1'b0;
        end else if (half_tick) begin
            blink <= ~blink;
        end
    end

    always_comb begin
        seg = SEG_ALL_DARK;
        case (phase)
            PHASE_INITIAL: begin
                seg[START_POS] = 1'b0;
            end
            PHASE_MOVING: begin
                seg[cursor.pos] = 1'b0;
            end
            PHASE_FALLING: begin
                seg = record;
                // Cursor goes dark on the odd half second
                seg[cursor.pos] = blink;
            end
            default: begin
                seg = SEG_ALL_DARK;
            end
        endcase
    end

endmodule

// File: logic/segment_walker.sv
`timescale 1ns/1ps

module segment_walker (
    input  logic                      clk,
    input  logic                      rst,
    input  seg_game_pkg::game_phase_t phase,
    input  button_pkg::btn_vec_t      btn_pulse,
    output seg_game_pkg::cursor_t     cursor,
    output seg_game_pkg::seg_bits_t   record,
    output logic                      all_lit
);
    import seg_game_pkg::*;

    cursor_t   next_cur;
    seg_bits_t fresh_record;
    seg_bits_t marked_record;

    // Walk rules, anything not listed holds position and heading
    always_comb begin
        next_cur = cursor;
        case (cursor.pos)
            POS_A: begin
                if (cursor.head == HEAD_RIGHT && btn_pulse.right) begin
                    next_cur = '{POS_B, HEAD_DOWN};
                end else if (cursor.head == HEAD_LEFT && btn_pulse.left) begin
                    next_cur = '{POS_F, HEAD_DOWN};
                end
            end
            POS_B: begin
                if (cursor.head == HEAD_UP && btn_pulse.left) begin
                    next_cur = '{POS_A, HEAD_LEFT};
                end else if (cursor.head == HEAD_DOWN && btn_pulse.right) begin
                    next_cur = '{POS_G, HEAD_LEFT};
                end else if (cursor.head == HEAD_DOWN && btn_pulse.up) begin
                    next_cur = '{POS_C, HEAD_DOWN};
                end
            end
            POS_C: begin
                if (cursor.head == HEAD_UP && btn_pulse.left) begin
                    next_cur = '{POS_G, HEAD_LEFT};
                end else if (cursor.head == HEAD_UP && btn_pulse.up) begin
                    next_cur = '{POS_B, HEAD_UP};
                end else if (cursor.head == HEAD_DOWN && btn_pulse.right) begin
                    next_cur = '{POS_D, HEAD_DOWN};
                end
            end
            POS_D: begin
                if (cursor.head == HEAD_RIGHT && btn_pulse.left) begin
                    next_cur = '{POS_C, HEAD_UP};
                end else if (cursor.head == HEAD_LEFT && btn_pulse.right) begin
                    next_cur = '{POS_E, HEAD_UP};
                end
            end
            POS_E: begin
                if (cursor.head == HEAD_UP && btn_pulse.right) begin
                    next_cur = '{POS_G, HEAD_RIGHT};
                end else if (cursor.head == HEAD_UP && btn_pulse.up) begin
                    next_cur = '{POS_F, HEAD_UP};
                end else if (cursor.head == HEAD_DOWN && btn_pulse.left) begin
                    next_cur = '{POS_D, HEAD_RIGHT};
                end
            end
            POS_F: begin
                if (cursor.head == HEAD_UP && btn_pulse.right) begin
                    next_cur = '{POS_A, HEAD_RIGHT};
                end else if (cursor.head == HEAD_DOWN && btn_pulse.left) begin
                    next_cur = '{POS_G, HEAD_RIGHT};
                end
            end
            POS_G: begin
                if (cursor.head == HEAD_RIGHT && btn_pulse.left) begin
                    next_cur = '{POS_B, HEAD_UP};
                end else if (cursor.head == HEAD_RIGHT && btn_pulse.right) begin
                    next_cur = '{POS_C, HEAD_DOWN};
                end else if (cursor.head == HEAD_LEFT && btn_pulse.left) begin
                    next_cur = '{POS_E, HEAD_DOWN};
                end else if (cursor.head == HEAD_LEFT && btn_pulse.right) begin
                    next_cur = '{POS_F, HEAD_UP};
                end
            end
            default: begin
                next_cur = cursor;
            end
        endcase
    end

    // Where the cursor lands is always marked as visited
    always_comb begin
        fresh_record                = SEG_ALL_DARK;
        fresh_record[next_cur.pos]  = 1'b0;
        marked_record               = record;
        marked_record[next_cur.pos] = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor <= '{START_POS, START_HEAD};
            record <= SEG_ALL_DARK;
        end else begin
            case (phase)
                PHASE_MOVING: begin
                    cursor <= next_cur;
                    if (btn_pulse.down) begin
                        record <= fresh_record;
                    end
                end
                PHASE_FALLING: begin
                    cursor <= next_cur;
                    record <= marked_record;
                end
                default: begin
                    cursor <= '{START_POS, START_HEAD};
                    record <= SEG_ALL_DARK;
                end
            endcase
        end
    end

    assign all_lit = (record == SEG_ALL_LIT);

    a_pos_in_range: assert property (
        @(posedge clk) disable iff (rst) cursor.pos <= POS_G
    );

endmodule

// File: logic/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      second_tick,
    input  logic                      half_tick,
    input  logic                      down_pulse,
    input  logic                      all_lit,
    output seg_game_pkg::game_phase_t phase
);
    import seg_game_pkg::*;

    logic [1:0]  seconds;
    logic        wait_done;
    game_phase_t phase_next;

    assign wait_done = second_tick && (seconds == 2'(INITIAL_WAIT_SECONDS - 1));

    always_comb begin
        phase_next = phase;
        case (phase)
            PHASE_INITIAL: begin
                if (wait_done) begin
                    phase_next = PHASE_MOVING;
                end
            end
            PHASE_MOVING: begin
                if (down_pulse) begin
                    phase_next = PHASE_FALLING;
                end
            end
            PHASE_FALLING: begin
                // Full digit holds until the next half tick
                if (half_tick && all_lit) begin
                    phase_next = PHASE_INITIAL;
                end
            end
            default: begin
                phase_next = PHASE_INITIAL;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= PHASE_INITIAL;
            seconds <= '0;
        end else begin
            phase <= phase_next;
            if (phase != PHASE_INITIAL) begin
                seconds <= '0;
            end else if (second_tick) begin
                seconds <= seconds + 2'd1;
            end
        end
    end

    a_no_skip_moving: assert property (
        @(posedge clk) disable iff (rst)
        (phase == PHASE_INITIAL) |=> (phase != PHASE_FALLING)
    );

endmodule

// File: logic/game_timer.sv
`timescale 1ns/1ps

module game_timer #(
    parameter int half_tick_cycles = seg_game_pkg::HALF_TICK_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic half_tick,
    output logic second_tick
);
    localparam int CNT_W = (half_tick_cycles > 1) ? $clog2(half_tick_cycles) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;
    logic             odd_half;

    assign wrap = (count == CNT_W'(half_tick_cycles - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count       <= '0;
            odd_half    <= 1'b0;
            half_tick   <= 1'b0;
            second_tick <= 1'b0;
        end else begin
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            half_tick   <= wrap;
            // Every other half tick closes a second
            second_tick <= wrap & odd_half;
            if (wrap) begin
                odd_half <= ~odd_half;
            end
        end
    end

    a_second_on_half: assert property (
        @(posedge clk) disable iff (rst) second_tick |-> half_tick
    );

endmodule

// File: logic/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic level,
    output logic pulse
);
    import button_pkg::*;

    logic                      level_sync;
    logic [DEBOUNCE_DEPTH-1:0] samples;
    logic                      stable;
    logic                      stable_d;

    // Pin is asynchronous to clk, so it is registered once before the window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_sync <= 1'b0;
            samples    <= '0;
            stable_d   <= 1'b0;
            pulse      <= 1'b0;
        end else begin
            level_sync <= level;
            samples    <= {samples[DEBOUNCE_DEPTH-2:0], level_sync};
            stable_d   <= stable;
            pulse      <= stable & ~stable_d;
        end
    end

    // Pressed only when the whole window is high
    assign stable = &samples;

    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst) pulse |=> !pulse
    );

endmodule

// File: logic/seg_game_pkg.sv
package seg_game_pkg;

    // Value equals the segment's bit index
    typedef enum logic [2:0] {
        POS_A = 3'd0,
        POS_B = 3'd1,
        POS_C = 3'd2,
        POS_D = 3'd3,
        POS_E = 3'd4,
        POS_F = 3'd5,
        POS_G = 3'd6
    } seg_pos_t;

    typedef enum logic [1:0] {
        HEAD_RIGHT = 2'd0,
        HEAD_LEFT  = 2'd1,
        HEAD_UP    = 2'd2,
        HEAD_DOWN  = 2'd3
    } heading_t;

    typedef enum logic [1:0] {
        PHASE_INITIAL = 2'd0,
        PHASE_MOVING  = 2'd1,
        PHASE_FALLING = 2'd2
    } game_phase_t;

    // Bit i is segment i, 0 lights it
    typedef logic [6:0] seg_bits_t;

    typedef struct packed {
        seg_pos_t pos;
        heading_t head;
    } cursor_t;

    localparam seg_bits_t SEG_ALL_DARK = 7'b111_1111;
    localparam seg_bits_t SEG_ALL_LIT  = 7'b000_0000;

    // Where every game starts
    localparam seg_pos_t START_POS  = POS_G;
    localparam heading_t START_HEAD = HEAD_LEFT;

    localparam int INITIAL_WAIT_SECONDS = 3;

    // Half a second at 50 MHz
    localparam int HALF_TICK_DEFAULT = 25_000_000;

endpackage

// File: logic/button_pkg.sv
package button_pkg;

    // Bit positions of each button inside btn_vec_t
    localparam int BTN_DOWN  = 0;
    localparam int BTN_UP    = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_RIGHT = 3;
    localparam int BTN_COUNT = 4;

    // Consecutive high samples that make a press
    localparam int DEBOUNCE_DEPTH = 4;

    // Raw levels or one-cycle pulses, right in the MSB
    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } btn_vec_t;

endpackage
